/* snakeGame_defs.svh */
// Geometry, buffer depth, LFSR seed, palette and TFT command of the snake core
// GRID_BITS must stay 4 because the apple LFSR splits one byte into x and y
// FIFO_DEPTH must be a power of two for the pointer wrap
`ifndef SNAKE_GAME_DEFS_SVH
`define SNAKE_GAME_DEFS_SVH

`define GRID_BITS    4
`define GRID_SIZE    16
`define MAX_LENGTH   16
`define FIFO_DEPTH   8
`define LFSR_SEED    8'hA5

// Memory write command that opens every frame
`define CMD_RAMWR    8'h2C

// Palette bytes for the five cell kinds
`define COLOR_EMPTY  8'h00
`define COLOR_BORDER 8'hFF
`define COLOR_BODY   8'h1C
`define COLOR_HEAD   8'h1F
`define COLOR_APPLE  8'hE0

`endif

/* snakePkg.sv */
// Types shared by every block of the snake core
// The direction encoding is chosen so that flipping bit 0 gives the reverse
`default_nettype none

package snakePkg;

    // Button bit i of dirBtn selects direction value i
    typedef enum logic [1:0] {
        dirUp    = 2'd0,
        dirDown  = 2'd1,
        dirLeft  = 2'd2,
        dirRight = 2'd3
    } dirT;

    typedef enum logic [2:0] {
        cellEmpty,
        cellBorder,
        cellBody,
        cellHead,
        cellApple
    } cellT;

    // Dcx is low for a command byte and high for a data byte
    typedef struct packed {
        logic       dcx;
        logic [7:0] data;
    } tftWordT;

endpackage

`default_nettype wire

/* snakeBody.sv */
// Snake segment store, steering, growth and collision checks
// Index 0 is the head; only the first length entries are live
// dirBtn bit i selects snakePkg::dirT value i and the lowest pressed bit wins
// A crashing step still pulses moveDone so the final position gets drawn
`default_nettype none
`include "snakeGame_defs.svh"

module snakeBody (
    input  logic clk,
    input  logic rstN,
    input  logic en,
    input  logic restart,
    input  logic step,
    input  logic [3:0] dirBtn,
    input  logic [`GRID_BITS-1:0] appleX,
    input  logic [`GRID_BITS-1:0] appleY,
    input  logic appleReady,
    output logic [`GRID_BITS-1:0] bodyX [`MAX_LENGTH],
    output logic [`GRID_BITS-1:0] bodyY [`MAX_LENGTH],
    output logic [$clog2(`MAX_LENGTH+1)-1:0] length,
    output logic moveDone,
    output logic ate,
    output logic gameOver
);

    snakePkg::dirT dir, nextDir;
    logic [`GRID_BITS-1:0] headX, headY;
    logic accept, willEat, grow, hitBorder, hitBody;

    // Steps only count while a free apple is on the field
    assign accept = step && en && !gameOver && appleReady;

    always_comb begin
        // A press that would reverse the snake onto itself is dropped
        nextDir = dir;
        for (int i = 3; i >= 0; i--) begin
            if (dirBtn[i] && (2'(i) != (dir ^ 2'b01))) begin
                nextDir = snakePkg::dirT'(2'(i));
            end
        end

        // Row 0 is the top of the field, so up lowers y
        headX = bodyX[0];
        headY = bodyY[0];
        case (nextDir)
            snakePkg::dirUp:   headY = bodyY[0] - 1'b1;
            snakePkg::dirDown: headY = bodyY[0] + 1'b1;
            snakePkg::dirLeft: headX = bodyX[0] - 1'b1;
            default:           headX = bodyX[0] + 1'b1;
        endcase

        willEat   = (headX == appleX) && (headY == appleY);
        grow      = willEat && (length < `MAX_LENGTH);
        hitBorder = (headX == 0) || (headX == `GRID_SIZE - 1) ||
                    (headY == 0) || (headY == `GRID_SIZE - 1);

        // The tail moves away on this step unless the snake grows
        hitBody = 1'b0;
        for (int i = 1; i < `MAX_LENGTH; i++) begin
            if ((i < length) && !((i == length - 1) && !grow) &&
                (bodyX[i] == headX) && (bodyY[i] == headY)) begin
                hitBody = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || restart) begin
            for (int i = 0; i < `MAX_LENGTH; i++) begin
                bodyX[i] <= '0;
                bodyY[i] <= '0;
            end
            // Start pose is a three cell snake facing right in the middle row
            bodyX[0] <= `GRID_BITS'd8;
            bodyX[1] <= `GRID_BITS'd7;
            bodyX[2] <= `GRID_BITS'd6;
            bodyY[0] <= `GRID_BITS'd8;
            bodyY[1] <= `GRID_BITS'd8;
            bodyY[2] <= `GRID_BITS'd8;
            dir      <= snakePkg::dirRight;
            length   <= 3;
            moveDone <= 1'b0;
            ate      <= 1'b0;
            gameOver <= 1'b0;
        end else begin
            moveDone <= accept;
            ate      <= 1'b0;
            if (accept) begin
                dir <= nextDir;
                if (hitBorder || hitBody) begin
                    gameOver <= 1'b1;
                end else begin
                    for (int i = 1; i < `MAX_LENGTH; i++) begin
                        bodyX[i] <= bodyX[i-1];
                        bodyY[i] <= bodyY[i-1];
                    end
                    bodyX[0] <= headX;
                    bodyY[0] <= headY;
                    ate      <= willEat;
                    if (grow) begin
                        length <= length + 1'b1;
                    end
                end
            end
        end
    end

    // Every drawn move keeps a legal snake length
    assert property (@(posedge clk) disable iff (!rstN)
        moveDone |-> (length >= 3) && (length <= `MAX_LENGTH));

    // Once the game is lost no apple can be eaten until restart
    assert property (@(posedge clk) disable iff (!rstN) gameOver |=> !ate);

endmodule

`default_nettype wire

/* appleGenerator.sv */
// Apple placement from an 8-bit LFSR, x in the high nibble and y in the low
// One proposal is checked per cycle, so appleReady can stay low for a while
// The apple position is only meaningful while appleReady is high
`default_nettype none
`include "snakeGame_defs.svh"

module appleGenerator (
    input  logic clk,
    input  logic rstN,
    input  logic restart,
    input  logic ate,
    input  logic [`GRID_BITS-1:0] bodyX [`MAX_LENGTH],
    input  logic [`GRID_BITS-1:0] bodyY [`MAX_LENGTH],
    input  logic [$clog2(`MAX_LENGTH+1)-1:0] length,
    output logic [`GRID_BITS-1:0] appleX,
    output logic [`GRID_BITS-1:0] appleY,
    output logic appleReady
);

    logic [2*`GRID_BITS-1:0] lfsr;
    logic feedback, onBorder, onBody;

    // Taps for x^8+x^6+x^5+x^4+1 with a left shift
    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
    assign appleX   = lfsr[2*`GRID_BITS-1:`GRID_BITS];
    assign appleY   = lfsr[`GRID_BITS-1:0];

    always_comb begin
        onBorder = (appleX == 0) || (appleX == `GRID_SIZE - 1) ||
                   (appleY == 0) || (appleY == `GRID_SIZE - 1);
        onBody = 1'b0;
        for (int i = 0; i < `MAX_LENGTH; i++) begin
            if ((i < length) && (bodyX[i] == appleX) && (bodyY[i] == appleY)) begin
                onBody = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || restart) begin
            lfsr       <= `LFSR_SEED;
            appleReady <= 1'b0;
        end else if (ate) begin
            // Eaten apple, so move on at least once before checking
            lfsr       <= {lfsr[2*`GRID_BITS-2:0], feedback};
            appleReady <= 1'b0;
        end else if (!appleReady) begin
            if (onBorder || onBody) begin
                lfsr <= {lfsr[2*`GRID_BITS-2:0], feedback};
            end else begin
                appleReady <= 1'b1;
            end
        end
    end

    // The snake and the scanner trust a ready apple to sit inside the wall
    assert property (@(posedge clk) disable iff (!rstN)
        appleReady |-> (appleX inside {[1:`GRID_SIZE-2]}) &&
                       (appleY inside {[1:`GRID_SIZE-2]}));

endmodule

`default_nettype wire

/* scoreTracker.sv */
// Three digit BCD score and high score
// The score wraps from 999 to 000; restart keeps the high score
`default_nettype none

module scoreTracker (
    input  logic clk,
    input  logic rstN,
    input  logic restart,
    input  logic ate,
    input  logic gameOver,
    output logic [11:0] scoreBcd,
    output logic [11:0] highBcd
);

    logic [11:0] bcdInc;
    logic carry, gameOverQ;

    // Ripple a single increment through the digits
    always_comb begin
        bcdInc = scoreBcd;
        carry  = 1'b1;
        for (int d = 0; d < 3; d++) begin
            if (carry) begin
                if (scoreBcd[4*d +: 4] == 4'd9) begin
                    bcdInc[4*d +: 4] = 4'd0;
                end else begin
                    bcdInc[4*d +: 4] = scoreBcd[4*d +: 4] + 4'd1;
                    carry            = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            scoreBcd  <= '0;
            highBcd   <= '0;
            gameOverQ <= 1'b0;
        end else begin
            gameOverQ <= gameOver;
            // Packed BCD compares in the same order as the numbers
            if (gameOver && !gameOverQ && (scoreBcd > highBcd)) begin
                highBcd <= scoreBcd;
            end
            if (restart) begin
                scoreBcd <= '0;
            end else if (ate) begin
                scoreBcd <= bcdInc;
            end
        end
    end

endmodule

`default_nettype wire

/* playfieldScanner.sv */
// Frame producer: one command word, then 256 cell colours in raster order
// A frame starts once a move or an apple change is pending and the apple is ready
// frameBusy drops only after the writer reports the 257th finished word
`default_nettype none
`include "snakeGame_defs.svh"

module playfieldScanner (
    input  logic clk,
    input  logic rstN,
    input  logic en,
    input  logic moveDone,
    input  logic appleReady,
    input  logic [`GRID_BITS-1:0] bodyX [`MAX_LENGTH],
    input  logic [`GRID_BITS-1:0] bodyY [`MAX_LENGTH],
    input  logic [$clog2(`MAX_LENGTH+1)-1:0] length,
    input  logic [`GRID_BITS-1:0] appleX,
    input  logic [`GRID_BITS-1:0] appleY,
    input  logic doneWord,
    output snakePkg::tftWordT wrData,
    output logic wrValid,
    input  logic wrReady,
    output logic frameBusy
);

    typedef enum logic [1:0] {stIdle, stCmd, stCells} stateT;

    stateT state;
    snakePkg::cellT kind;
    logic [2*`GRID_BITS-1:0] idx, loadIdx;
    logic [`GRID_BITS-1:0] cellX, cellY;
    logic [7:0] colour;
    logic [8:0] doneCnt;
    logic pending, start, take;

    assign take    = wrValid && wrReady;
    assign start   = (state == stIdle) && !frameBusy && pending && appleReady && en;
    // The cell loaded next is 0 after the command, else the following one
    assign loadIdx = (state == stCmd) ? '0 : idx + 1'b1;
    assign cellX   = loadIdx[`GRID_BITS-1:0];
    assign cellY   = loadIdx[2*`GRID_BITS-1:`GRID_BITS];

    // Later checks override earlier ones, giving head the top priority
    always_comb begin
        kind = snakePkg::cellEmpty;
        if ((cellX == 0) || (cellX == `GRID_SIZE - 1) ||
            (cellY == 0) || (cellY == `GRID_SIZE - 1)) begin
            kind = snakePkg::cellBorder;
        end
        if ((cellX == appleX) && (cellY == appleY)) begin
            kind = snakePkg::cellApple;
        end
        for (int i = 1; i < `MAX_LENGTH; i++) begin
            if ((i < length) && (bodyX[i] == cellX) && (bodyY[i] == cellY)) begin
                kind = snakePkg::cellBody;
            end
        end
        if ((bodyX[0] == cellX) && (bodyY[0] == cellY)) begin
            kind = snakePkg::cellHead;
        end
        case (kind)
            snakePkg::cellBorder: colour = `COLOR_BORDER;
            snakePkg::cellBody:   colour = `COLOR_BODY;
            snakePkg::cellHead:   colour = `COLOR_HEAD;
            snakePkg::cellApple:  colour = `COLOR_APPLE;
            default:              colour = `COLOR_EMPTY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= stIdle;
            wrValid   <= 1'b0;
            pending   <= 1'b1;
            frameBusy <= 1'b0;
            doneCnt   <= '0;
            idx       <= '0;
        end else begin
            // A low appleReady also covers restart and a freshly eaten apple
            if (start) begin
                pending <= 1'b0;
            end
            if (moveDone || !appleReady) begin
                pending <= 1'b1;
            end

            case (state)
                stIdle: begin
                    if (start) begin
                        state     <= stCmd;
                        wrValid   <= 1'b1;
                        wrData    <= {1'b0, `CMD_RAMWR};
                        frameBusy <= 1'b1;
                        doneCnt   <= '0;
                    end
                end
                stCmd: begin
                    if (take) begin
                        state  <= stCells;
                        idx    <= loadIdx;
                        wrData <= {1'b1, colour};
                    end
                end
                default: begin
                    if (take && (idx == '1)) begin
                        state   <= stIdle;
                        wrValid <= 1'b0;
                    end else if (take) begin
                        idx    <= loadIdx;
                        wrData <= {1'b1, colour};
                    end
                end
            endcase

            if (doneWord) begin
                doneCnt <= doneCnt + 1'b1;
                if (doneCnt == 9'd256) begin
                    frameBusy <= 1'b0;
                end
            end
        end
    end

    // The FIFO may stall at any time and the offered word must wait intact
    assert property (@(posedge clk) disable iff (!rstN)
        wrValid && !wrReady |=> wrValid && $stable(wrData));

endmodule

`default_nettype wire

/* tftFifo.sv */
// Synchronous FIFO of TFT words with valid/ready on both ends
// rdData shows the oldest entry whenever rdValid is high
`default_nettype none
`include "snakeGame_defs.svh"

module tftFifo (
    input  logic clk,
    input  logic rstN,
    input  snakePkg::tftWordT wrData,
    input  logic wrValid,
    output logic wrReady,
    output snakePkg::tftWordT rdData,
    output logic rdValid,
    input  logic rdReady
);

    localparam int PtrW = $clog2(`FIFO_DEPTH);

    snakePkg::tftWordT mem [`FIFO_DEPTH];
    logic [PtrW-1:0] wrPtr, rdPtr;
    logic [PtrW:0] count;
    logic push, pop;

    assign wrReady = (count != `FIFO_DEPTH);
    assign rdValid = (count != 0);
    assign rdData  = mem[rdPtr];
    assign push    = wrValid && wrReady;
    assign pop     = rdValid && rdReady;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= wrData;
        end
    end

    // Pointers wrap by overflow, so the count tells full from empty
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            wrPtr <= wrPtr + PtrW'(push);
            rdPtr <= rdPtr + PtrW'(pop);
            count <= count + (PtrW+1)'(push) - (PtrW+1)'(pop);
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) count <= `FIFO_DEPTH);

endmodule

`default_nettype wire

/* tftWriter.sv */
// Drives an 8-bit MCU style TFT bus from the FIFO
// Each word gets one low and one high cycle of tftWr, the panel latching on the rise
// A new word is only taken while tftBusy is low
`default_nettype none

module tftWriter (
    input  logic clk,
    input  logic rstN,
    input  snakePkg::tftWordT rdData,
    input  logic rdValid,
    output logic rdReady,
    input  logic tftBusy,
    output logic tftWr,
    output logic tftDcx,
    output logic [7:0] tftData,
    output logic doneWord
);

    typedef enum logic [1:0] {stIdle, stStrobe, stHold} stateT;

    stateT state;

    // The high half of one strobe overlaps the fetch of the next word
    assign rdReady  = (state != stStrobe) && !tftBusy;
    // Hold lasts exactly one cycle, so this pulses once per word
    assign doneWord = (state == stHold);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= stIdle;
            tftWr   <= 1'b1;
            tftDcx  <= 1'b0;
            tftData <= '0;
        end else begin
            case (state)
                stStrobe: begin
                    state <= stHold;
                    tftWr <= 1'b1;
                end
                default: begin
                    if (rdValid && rdReady) begin
                        tftData <= rdData.data;
                        tftDcx  <= rdData.dcx;
                        tftWr   <= 1'b0;
                        state   <= stStrobe;
                    end else begin
                        state <= stIdle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* snakeGame.sv */
// Top of the snake core, game logic feeding a buffered TFT frame stream
// Steps arriving while a frame is still on the bus are ignored
`default_nettype none
`include "snakeGame_defs.svh"

module snakeGame (
    input  logic clk,
    input  logic rstN,
    input  logic en,
    input  logic restart,
    input  logic step,
    input  logic [3:0] dirBtn,
    input  logic tftBusy,
    output logic tftWr,
    output logic tftDcx,
    output logic [7:0] tftData,
    output logic [11:0] scoreBcd,
    output logic [11:0] highBcd,
    output logic gameOver,
    output logic frameBusy
);

    logic [`GRID_BITS-1:0] bodyX [`MAX_LENGTH];
    logic [`GRID_BITS-1:0] bodyY [`MAX_LENGTH];
    logic [$clog2(`MAX_LENGTH+1)-1:0] length;
    logic [`GRID_BITS-1:0] appleX, appleY;
    logic appleReady, moveDone, ate, doneWord;
    logic wrValid, wrReady, rdValid, rdReady;
    snakePkg::tftWordT wrData, rdData;

    // Game state, frozen for steps while a frame is drawn
    snakeBody body0 (
        .clk(clk), .rstN(rstN), .en(en && !frameBusy), .restart(restart),
        .step(step), .dirBtn(dirBtn), .appleX(appleX), .appleY(appleY),
        .appleReady(appleReady), .bodyX(bodyX), .bodyY(bodyY), .length(length),
        .moveDone(moveDone), .ate(ate), .gameOver(gameOver)
    );

    appleGenerator apple0 (
        .clk(clk), .rstN(rstN), .restart(restart), .ate(ate),
        .bodyX(bodyX), .bodyY(bodyY), .length(length),
        .appleX(appleX), .appleY(appleY), .appleReady(appleReady)
    );

    scoreTracker score0 (
        .clk(clk), .rstN(rstN), .restart(restart), .ate(ate),
        .gameOver(gameOver), .scoreBcd(scoreBcd), .highBcd(highBcd)
    );

    // Producer, buffer and consumer of the frame stream
    playfieldScanner scan0 (
        .clk(clk), .rstN(rstN), .en(en), .moveDone(moveDone),
        .appleReady(appleReady), .bodyX(bodyX), .bodyY(bodyY), .length(length),
        .appleX(appleX), .appleY(appleY), .doneWord(doneWord), .wrData(wrData),
        .wrValid(wrValid), .wrReady(wrReady), .frameBusy(frameBusy)
    );

    tftFifo fifo0 (
        .clk(clk), .rstN(rstN), .wrData(wrData), .wrValid(wrValid),
        .wrReady(wrReady), .rdData(rdData), .rdValid(rdValid), .rdReady(rdReady)
    );

    tftWriter writer0 (
        .clk(clk), .rstN(rstN), .rdData(rdData), .rdValid(rdValid),
        .rdReady(rdReady), .tftBusy(tftBusy), .tftWr(tftWr), .tftDcx(tftDcx),
        .tftData(tftData), .doneWord(doneWord)
    );

endmodule

`default_nettype wire

/* tbSnakeGame.sv */
// Directed testbench for the snake core with a reference model of the game
// Bus bytes are taken on each falling edge of tftWr, seen at the falling clock edge
// All stimulus, tftBusy included, changes 1 time unit after the rising clock edge
`default_nettype none
`include "snakeGame_defs.svh"

module tbSnakeGame;

    logic clk = 1'b0;
    logic rstN, en, restart, step, tftBusy;
    logic [3:0] dirBtn;
    logic tftWr, tftDcx, gameOver, frameBusy;
    logic [7:0] tftData;
    logic [11:0] scoreBcd, highBcd;

    // Reference model, index 0 of the arrays is the head
    int mX [16];
    int mY [16];
    int mLen, mDir, mScore, mHigh;
    bit mOver;
    logic [7:0] mLfsr;

    // Every byte seen on the bus, as {dcx, data}
    logic [8:0] capQ [$];
    logic prevWr;
    integer seed = 30914;
    int errors, checks, testErrBase, testsRun, testsFailed;
    int frameBase, stallCount, moves;
    bit stallOn;
    string curTest;

    snakeGame dut0 (
        .clk(clk), .rstN(rstN), .en(en), .restart(restart), .step(step),
        .dirBtn(dirBtn), .tftBusy(tftBusy), .tftWr(tftWr), .tftDcx(tftDcx),
        .tftData(tftData), .scoreBcd(scoreBcd), .highBcd(highBcd),
        .gameOver(gameOver), .frameBusy(frameBusy)
    );

    always #4 clk = ~clk;

    // A low phase of tftWr lasts one whole clock, so mid-cycle sampling sees it
    always @(negedge clk) begin
        if (prevWr && !tftWr) begin
            capQ.push_back({tftDcx, tftData});
        end
        prevWr <= tftWr;
    end

    // Polynomial x^8+x^6+x^5+x^4+1 on a left shift
    function automatic logic [7:0] lfsrNext(input logic [7:0] v);
        return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
    endfunction

    function automatic bit onBorder(input int x, input int y);
        return (x == 0) || (x == 15) || (y == 0) || (y == 15);
    endfunction

    // True when a live segment from index first onward covers the cell
    function automatic bit onSnake(input int x, input int y, input int first);
        for (int i = first; i < mLen; i++) begin
            if ((mX[i] == x) && (mY[i] == y)) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Head beats body, body beats apple, apple beats the wall
    function automatic logic [7:0] modelColour(input int x, input int y);
        return ((mX[0] == x) && (mY[0] == y)) ? `COLOR_HEAD :
               onSnake(x, y, 1) ? `COLOR_BODY :
               ((x == mLfsr[7:4]) && (y == mLfsr[3:0])) ? `COLOR_APPLE :
               onBorder(x, y) ? `COLOR_BORDER : `COLOR_EMPTY;
    endfunction

    function automatic logic [11:0] toBcd(input int v);
        return {4'(v / 100), 4'((v / 10) % 10), 4'(v % 10)};
    endfunction

    task automatic placeApple();
        int tries;
        tries = 0;
        // Stop at the first proposal that is inside the wall and off the snake
        while ((onBorder(mLfsr[7:4], mLfsr[3:0]) || onSnake(mLfsr[7:4], mLfsr[3:0], 0))
               && (tries < 256)) begin
            mLfsr = lfsrNext(mLfsr);
            tries++;
        end
    endtask

    task automatic modelRestart();
        for (int i = 0; i < 16; i++) begin
            mX[i] = 0;
            mY[i] = 0;
        end
        mX[0] = 8;
        mX[1] = 7;
        mX[2] = 6;
        mY[0] = 8;
        mY[1] = 8;
        mY[2] = 8;
        mLen = 3;
        mDir = 3;
        mScore = 0;
        mOver = 1'b0;
        mLfsr = `LFSR_SEED;
        placeApple();
    endtask

    task automatic modelStep(input logic [3:0] btn);
        int nx, ny, kept;
        bit found, eat, grow, bad;
        found = 1'b0;
        // Button i means direction i; a reverse press is dropped
        for (int i = 0; i < 4; i++) begin
            if (btn[i] && !found && (i != (mDir ^ 1))) begin
                mDir = i;
                found = 1'b1;
            end
        end
        nx = mX[0] + ((mDir == 3) ? 1 : (mDir == 2) ? -1 : 0);
        ny = mY[0] + ((mDir == 1) ? 1 : (mDir == 0) ? -1 : 0);
        eat = (nx == mLfsr[7:4]) && (ny == mLfsr[3:0]);
        grow = eat && (mLen < 16);
        // Without growth the tail cell is vacated by this very move
        kept = grow ? mLen : mLen - 1;
        bad = onBorder(nx, ny);
        for (int i = 0; i < kept; i++) begin
            if ((mX[i] == nx) && (mY[i] == ny)) begin
                bad = 1'b1;
            end
        end
        if (bad) begin
            mOver = 1'b1;
            if (mScore > mHigh) begin
                mHigh = mScore;
            end
        end else begin
            for (int i = 15; i > 0; i--) begin
                mX[i] = mX[i-1];
                mY[i] = mY[i-1];
            end
            mX[0] = nx;
            mY[0] = ny;
            if (grow) begin
                mLen++;
            end
            if (eat) begin
                mScore = (mScore + 1) % 1000;
                mLfsr = lfsrNext(mLfsr);
                placeApple();
            end
        end
    endtask

    task automatic nextCycle();
        int r;
        @(posedge clk);
        #1;
        r = $random(seed);
        tftBusy = stallOn && r[0];
        if (tftBusy) begin
            stallCount++;
        end
    endtask

    task automatic failTimeout(input string what);
        $display("ERROR in test %s: no %s before the timeout", curTest, what);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic checkValue(input string what, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            $display("MISMATCH test %s: %s expected %0h actual %0h",
                     curTest, what, expected, actual);
            errors++;
        end
    endtask

    task automatic waitFrameStart();
        int n;
        n = 0;
        // An eaten apple can keep the frame back for many reroll cycles
        while (!frameBusy && (n < 1000)) begin
            nextCycle();
            n++;
        end
        if (!frameBusy) begin
            failTimeout("frame start");
        end
    endtask

    task automatic waitIdle();
        int n;
        n = 0;
        while (frameBusy && (n < 10000)) begin
            nextCycle();
            n++;
        end
        if (frameBusy) begin
            failTimeout("frame end");
        end
    endtask

    task automatic checkFrame();
        int n, errBefore;
        logic [8:0] expWord;
        n = capQ.size() - frameBase;
        checkValue("frame word count", 257, n);
        if (n == 257) begin
            for (int k = 0; k < 257; k++) begin
                // Word 0 is the command, then x runs fastest within each row
                expWord = (k == 0) ? {1'b0, `CMD_RAMWR} :
                          {1'b1, modelColour((k - 1) % 16, (k - 1) / 16)};
                errBefore = errors;
                checkValue($sformatf("word %0d", k), expWord, capQ[frameBase + k]);
                if (errors != errBefore) begin
                    break;
                end
            end
        end
    endtask

    task automatic expectNoFrame();
        bit seen;
        seen = 1'b0;
        // A real frame would begin within a few cycles of the step
        for (int i = 0; i < 60; i++) begin
            nextCycle();
            if (frameBusy) begin
                seen = 1'b1;
            end
        end
        checks++;
        assert (!seen && (capQ.size() == frameBase)) else begin
            $display("ERROR in test %s: a frame was sent after an ignored step", curTest);
            errors++;
        end
    endtask

    task automatic doStep(input logic [3:0] btn);
        waitIdle();
        frameBase = capQ.size();
        step = 1'b1;
        dirBtn = btn;
        nextCycle();
        step = 1'b0;
        dirBtn = 4'b0000;
        if (en && !mOver) begin
            modelStep(btn);
        end
    endtask

    task automatic stepAndCheck(input logic [3:0] btn);
        doStep(btn);
        waitFrameStart();
        waitIdle();
        checkFrame();
        checkValue("scoreBcd", toBcd(mScore), scoreBcd);
        checkValue("highBcd", toBcd(mHigh), highBcd);
        checkValue("gameOver", mOver, gameOver);
    endtask

    task automatic beginTest(input string name);
        curTest = name;
        testErrBase = errors;
    endtask

    task automatic endTest();
        testsRun++;
        if (errors != testErrBase) begin
            testsFailed++;
            $display("test %s: failed with %0d errors", curTest, errors - testErrBase);
        end else begin
            $display("test %s: passed", curTest);
        end
    endtask

    initial begin
        rstN = 1'b0;
        en = 1'b1;
        restart = 1'b0;
        step = 1'b0;
        dirBtn = 4'b0000;
        tftBusy = 1'b0;
        stallOn = 1'b0;
        errors = 0;
        checks = 0;
        testsRun = 0;
        testsFailed = 0;
        mHigh = 0;
        curTest = "reset";
        modelRestart();
        for (int i = 0; i < 10; i++) begin
            nextCycle();
        end
        rstN = 1'b1;

        beginTest("resetFrame");
        frameBase = 0;
        waitFrameStart();
        waitIdle();
        checkFrame();
        checkValue("scoreBcd", 0, scoreBcd);
        checkValue("gameOver", 0, gameOver);
        endTest();

        // Left and down are each pressed against the current heading
        beginTest("steering");
        stepAndCheck(4'b0100);
        stepAndCheck(4'b0001);
        stepAndCheck(4'b0010);
        stepAndCheck(4'b1000);
        endTest();

        // The start apple sits right above the head now
        beginTest("eatApple");
        stepAndCheck(4'b0001);
        checkValue("scoreBcd after one apple", 12'h001, scoreBcd);
        endTest();

        beginTest("crashRestart");
        moves = 0;
        while (!mOver && (moves < 16)) begin
            stepAndCheck(4'b0001);
            moves++;
        end
        checkValue("gameOver", 1, gameOver);
        doStep(4'b0001);
        expectNoFrame();
        frameBase = capQ.size();
        restart = 1'b1;
        nextCycle();
        restart = 1'b0;
        modelRestart();
        waitFrameStart();
        waitIdle();
        checkFrame();
        checkValue("scoreBcd", 0, scoreBcd);
        checkValue("highBcd", toBcd(mHigh), highBcd);
        checkValue("gameOver", 0, gameOver);
        endTest();

        beginTest("busyStalls");
        stallOn = 1'b1;
        stallCount = 0;
        stepAndCheck(4'b1000);
        stallOn = 1'b0;
        checks++;
        assert (stallCount > 0) else begin
            $display("ERROR in test %s: tftBusy never stalled the bus", curTest);
            errors++;
        end
        endTest();

        // The frame after the enabled step shows whether the first one moved
        beginTest("enableLow");
        en = 1'b0;
        doStep(4'b1000);
        expectNoFrame();
        checkValue("gameOver", 0, gameOver);
        en = 1'b1;
        stepAndCheck(4'b1000);
        endTest();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
snakePkg.sv
snakeBody.sv
appleGenerator.sv
scoreTracker.sv
playfieldScanner.sv
tftFifo.sv
tftWriter.sv
snakeGame.sv
tbSnakeGame.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the snake core testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tbSnakeGame -f flist.f \
    && ./obj_dir/VtbSnakeGame | tee sim.log \
    || echo "build or simulation stopped with an error"
# The log decides the result
grep -qx "SIMULATION PASSED" sim.log && echo "run passed" && exit 0 \
    || { echo "run failed"; exit 1; }
